//--- sources.f
hw/rmii_tx_pkg.sv
hw/tx_frame_store.sv
hw/fcs_appender.sv
hw/rmii_byte_shipper.sv
hw/rmii_tx_top.sv
verification/tb_clock_gen.sv
verification/rmii_tx_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the RMII transmit testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sources.f --top-module rmii_tx_tb -o rmii_tx_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/rmii_tx_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "All tests passed" sim.log; then
    exit 0
fi
exit 1

//--- verification/rmii_tx_trace.txt
# name speed_code(hex) byte_count chained payload_bytes(hex)... fcs(hex, sent low byte first)
# chained 1 writes the next record right behind this one
check_digits_100 1 9 0
31 32 33 34 35 36 37 38 39
cbf43926
check_digits_10 0 9 0
31 32 33 34 35 36 37 38 39
cbf43926
pair_first 1 3 1
61 62 63
352441c2
pair_second 1 1 0
61
e8b7be43
store_fill 1 43 0
54 68 65 20 71 75 69 63 6b 20 62 72 6f 77 6e 20
66 6f 78 20 6a 75 6d 70 73 20 6f 76 65 72 20 74
68 65 20 6c 61 7a 79 20 64 6f 67
414fa339

//--- verification/rmii_tx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rmii_tx_tb
    import rmii_tx_pkg::*;
();

    // Small store so the fill frame can be a known CRC vector
    localparam int depth = 43;
    localparam int max_records = 16;
    localparam int preamble_run = 31;
    localparam int slow_hold = 10;

    logic        clock;
    logic        reset_n;
    logic [7:0]  frame_byte;
    logic        frame_last;
    logic        frame_write;
    speed_code_t speed_code;
    logic [1:0]  tx_data;
    logic        tx_enable;
    logic        store_full;

    string       names [max_records];
    int          speeds [max_records];
    int          counts [max_records];
    int          chained [max_records];
    logic [31:0] fcs_values [max_records];
    int          offsets [max_records];
    logic [7:0]  payload [$];
    int          record_total;
    int          cycle_count = 0;
    int          cycle_limit;

    tb_clock_gen clock_gen_i (
        .clock   (clock),
        .reset_n (reset_n)
    );

    rmii_tx_top #(
        .STORE_DEPTH (depth)
    ) rmii_tx_top_i (
        .clock       (clock),
        .reset_n     (reset_n),
        .frame_byte  (frame_byte),
        .frame_last  (frame_last),
        .frame_write (frame_write),
        .speed_code  (speed_code),
        .tx_data     (tx_data),
        .tx_enable   (tx_enable),
        .store_full  (store_full)
    );

    ////////////////////
    // Error reporting

    task automatic stop_with_message(input string message);
        $display("%s", message);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string test, input string what,
                              input tx_word_t expected, input tx_word_t actual);
        if (expected !== actual) begin
            $display("FAILED %s: %s expected %h actual %h", test, what, expected, actual);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string test, input string what,
                              input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("FAILED %s: %s expected %b actual %b", test, what, expected, actual);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_dibit(input string test, input string what,
                               input logic [1:0] expected, input logic [1:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: %s expected %b actual %b", test, what, expected, actual);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles waiting for the DUT", cycle_count);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    ////////////////////
    // Trace reading

    task automatic read_trace();
        int    fd;
        string token;
        string rest;
        int    value;
        int    byte_value;
        begin
            fd = $fopen("verification/rmii_tx_trace.txt", "r");
            if (fd == 0) begin
                stop_with_message("Cannot open verification/rmii_tx_trace.txt");
            end
            record_total = 0;
            while ($fscanf(fd, "%s", token) == 1) begin
                if (token == "#") begin
                    value = $fgets(rest, fd);
                end else begin
                    names[record_total] = token;
                    value = $fscanf(fd, "%h %d %d", speeds[record_total],
                                    counts[record_total], chained[record_total]);
                    offsets[record_total] = payload.size();
                    for (int i = 0; i < counts[record_total]; i++) begin
                        value = $fscanf(fd, "%h", byte_value);
                        payload.push_back(8'(byte_value));
                    end
                    value = $fscanf(fd, "%h", fcs_values[record_total]);
                    record_total++;
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////
    // Host writes and line monitor

    task automatic write_frame(input int r);
        for (int i = 0; i < counts[r]; i++) begin
            @(posedge clock);
            #1;
            check_flag(names[r], "store_full before write", 1'b0, store_full);
            speed_code = speed_code_t'(speeds[r]);
            frame_byte = payload[offsets[r] + i];
            frame_last = (i == counts[r] - 1);
            frame_write = 1'b1;
        end
        @(posedge clock);
        #1;
        frame_write = 1'b0;
        frame_last = 1'b0;
        if (counts[r] == depth) begin
            check_flag(names[r], "store_full after last write", 1'b1, store_full);
            while (store_full) begin
                @(negedge clock);
            end
        end
    endtask

    task automatic receive_frame(input int r);
        logic [1:0] samples [$];
        logic [1:0] dibits [$];
        logic [1:0] mid;
        logic [7:0] expected_byte;
        logic [7:0] actual_byte;
        tx_word_t   expected_word;
        tx_word_t   actual_word;
        int         hold;
        int         run;
        int         base;
        begin
            hold = (speeds[r] == 0) ? slow_hold : 1;
            do @(negedge clock); while (!tx_enable);
            while (tx_enable) begin
                samples.push_back(tx_data);
                @(negedge clock);
            end
            if (samples.size() % hold != 0) begin
                stop_with_message($sformatf("%s: tx_enable burst of %0d clocks is not whole dibits",
                                            names[r], samples.size()));
            end
            for (int i = 0; i < samples.size() / hold; i++) begin
                mid = samples[i * hold + hold / 2];
                for (int j = 0; j < hold; j++) begin
                    if (samples[i * hold + j] !== mid) begin
                        stop_with_message($sformatf("%s: dibit %0d changed inside its hold time",
                                                    names[r], i));
                    end
                end
                dibits.push_back(mid);
            end
            run = 0;
            while (run < dibits.size() && dibits[run] == 2'b01) begin
                run++;
            end
            if (run != preamble_run) begin
                stop_with_message($sformatf("%s: preamble had %0d dibits instead of %0d",
                                            names[r], run, preamble_run));
            end
            if (dibits.size() != run + 1 + 4 * (counts[r] + 4)) begin
                stop_with_message($sformatf("%s: frame carried %0d dibits, wrong length",
                                            names[r], dibits.size()));
            end
            check_dibit(names[r], "start of frame dibit", 2'b11, dibits[run]);
            // Payload then FCS with each byte low dibit first
            for (int k = 0; k < counts[r] + 4; k++) begin
                base = run + 1 + 4 * k;
                actual_byte = {dibits[base + 3], dibits[base + 2],
                               dibits[base + 1], dibits[base]};
                if (k < counts[r]) begin
                    expected_byte = payload[offsets[r] + k];
                end else begin
                    expected_byte = fcs_values[r][8 * (k - counts[r]) +: 8];
                end
                expected_word = '{marker: 1'b0, value: expected_byte};
                actual_word = '{marker: 1'b0, value: actual_byte};
                check_word(names[r], $sformatf("byte %0d", k), expected_word, actual_word);
            end
        end
    endtask

    ////////////////////
    // Test sequence

    initial begin
        int r;
        frame_byte = 8'h00;
        frame_last = 1'b0;
        frame_write = 1'b0;
        speed_code = speed_100_megabit;
        cycle_limit = 0;
        read_trace();
        for (int i = 0; i < record_total; i++) begin
            cycle_limit += (counts[i] + 12) * 4 * 10;
        end
        cycle_limit += 200;

        @(posedge reset_n);
        @(negedge clock);
        check_flag("reset", "tx_enable after reset", 1'b0, tx_enable);
        check_flag("reset", "store_full after reset", 1'b0, store_full);
        repeat (20) begin
            @(negedge clock);
            check_flag("idle", "tx_enable with no frame", 1'b0, tx_enable);
        end

        r = 0;
        while (r < record_total) begin
            if (chained[r] != 0 && r + 1 < record_total) begin
                fork
                    begin
                        write_frame(r);
                        write_frame(r + 1);
                    end
                    begin
                        receive_frame(r);
                        receive_frame(r + 1);
                    end
                join
                r += 2;
            end else begin
                fork
                    write_frame(r);
                    receive_frame(r);
                join
                r += 1;
            end
        end

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int RESET_CYCLES = 16
) (
    output logic clock,
    output logic reset_n
);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Release just after an edge, like the other stimulus
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #1 reset_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- hw/rmii_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

module rmii_tx_top
    import rmii_tx_pkg::*;
#(
    parameter int STORE_DEPTH = 64
) (
    input  wire              clock,
    input  wire              reset_n,
    input  wire [7:0]        frame_byte,
    input  wire              frame_last,
    input  wire              frame_write,
    input  wire speed_code_t speed_code,
    output logic [1:0]       tx_data,
    output logic             tx_enable,
    output logic             store_full
);

    store_entry_t host_entry;
    store_entry_t head_entry;
    logic         frame_available;
    logic         pop;
    tx_word_t     shipper_word;
    logic         shipper_word_enable;
    logic         shipper_ready;

    assign host_entry = '{last: frame_last, value: frame_byte};

    ////////////////////
    // Frame store

    tx_frame_store #(
        .payload_t   (store_entry_t),
        .STORE_DEPTH (STORE_DEPTH)
    ) store_i (
        .clock           (clock),
        .reset_n         (reset_n),
        .write_entry     (host_entry),
        .write_last      (frame_last),
        .write           (frame_write),
        .full            (store_full),
        .frame_available (frame_available),
        .head_entry      (head_entry),
        .pop             (pop)
    );

    // FCS and framing
    fcs_appender appender_i (
        .clock           (clock),
        .reset_n         (reset_n),
        .frame_available (frame_available),
        .head_entry      (head_entry),
        .pop             (pop),
        .data            (shipper_word),
        .data_enable     (shipper_word_enable),
        .data_ready      (shipper_ready)
    );

    // RMII line side
    rmii_byte_shipper shipper_i (
        .clock              (clock),
        .reset_n            (reset_n),
        .data               (shipper_word),
        .data_enable        (shipper_word_enable),
        .speed_code         (speed_code),
        .shipped_data       (tx_data),
        .shipped_data_valid (tx_enable),
        .data_ready         (shipper_ready)
    );

endmodule

`default_nettype wire

//--- hw/rmii_byte_shipper.sv
`timescale 1ns/1ps
`default_nettype none

module rmii_byte_shipper
    import rmii_tx_pkg::*;
(
    input  wire              clock,
    input  wire              reset_n,
    input  wire tx_word_t    data,
    input  wire              data_enable,
    input  wire speed_code_t speed_code,
    output logic [1:0]       shipped_data,
    output logic             shipped_data_valid,
    output logic             data_ready
);

    typedef enum logic [1:0] {
        st_idle,
        st_preamble,
        st_start_of_frame,
        st_data
    } state_t;

    state_t      state;
    state_t      state_next;
    logic [8:0]  preamble_counter;
    logic [8:0]  preamble_counter_next;
    logic [3:0]  sample_counter;
    logic [3:0]  sample_counter_next;
    logic [1:0]  dibit_index;
    logic [1:0]  dibit_index_next;
    logic [7:0]  byte_to_ship;
    logic [7:0]  byte_to_ship_next;
    logic [1:0]  shipped_data_next;
    logic        shipped_data_valid_next;
    logic        data_ready_next;
    speed_code_t speed_latched;
    speed_code_t speed_latched_next;
    logic [3:0]  sample_limit;
    logic [8:0]  preamble_limit;

    ////////////////////
    // Per-speed limits

    always_comb begin
        case (speed_latched)
            speed_100_megabit: begin
                sample_limit = 4'd0;
                preamble_limit = 9'(preamble_dibits - 1);
            end
            speed_10_megabit: begin
                sample_limit = 4'(hold_clocks_10_megabit - 1);
                preamble_limit = 9'(preamble_dibits * hold_clocks_10_megabit - 1);
            end
            default: begin
                sample_limit = 4'd0;
                preamble_limit = 9'(preamble_dibits - 1);
            end
        endcase
    end

    ////////////////////
    // Frame sequencing

    always_comb begin
        state_next = state;
        preamble_counter_next = preamble_counter;
        sample_counter_next = sample_counter;
        dibit_index_next = dibit_index;
        byte_to_ship_next = byte_to_ship;
        shipped_data_next = shipped_data;
        shipped_data_valid_next = shipped_data_valid;
        speed_latched_next = speed_latched;
        data_ready_next = 1'b0;

        case (state)
            st_idle: begin
                data_ready_next = 1'b1;
                shipped_data_next = 2'b00;
                shipped_data_valid_next = 1'b0;
                speed_latched_next = speed_code;
                sample_counter_next = '0;
                preamble_counter_next = '0;
                if (data_enable && data.marker) begin
                    data_ready_next = 1'b0;
                    byte_to_ship_next = data.value;
                    shipped_data_next = 2'b01;
                    shipped_data_valid_next = 1'b1;
                    state_next = st_preamble;
                end
            end
            st_preamble: begin
                // Counted in clocks, so the limit already covers the hold time
                if (preamble_counter == preamble_limit) begin
                    shipped_data_next = 2'b11;
                    state_next = st_start_of_frame;
                end else begin
                    preamble_counter_next = preamble_counter + 1'b1;
                end
            end
            st_start_of_frame: begin
                if (sample_counter == sample_limit) begin
                    sample_counter_next = '0;
                    shipped_data_next = byte_to_ship[1:0];
                    byte_to_ship_next = {2'b00, byte_to_ship[7:2]};
                    dibit_index_next = '0;
                    state_next = st_data;
                end else begin
                    sample_counter_next = sample_counter + 1'b1;
                end
            end
            st_data: begin
                if (sample_counter == sample_limit) begin
                    sample_counter_next = '0;
                    if (dibit_index == 2'(dibits_per_byte - 1)) begin
                        // End of byte takes the next word or closes the frame
                        if (data_enable && !data.marker) begin
                            shipped_data_next = data.value[1:0];
                            byte_to_ship_next = {2'b00, data.value[7:2]};
                            dibit_index_next = '0;
                            data_ready_next = 1'b1;
                        end else begin
                            shipped_data_next = 2'b00;
                            shipped_data_valid_next = 1'b0;
                            state_next = st_idle;
                        end
                    end else begin
                        shipped_data_next = byte_to_ship[1:0];
                        byte_to_ship_next = {2'b00, byte_to_ship[7:2]};
                        dibit_index_next = dibit_index + 1'b1;
                    end
                end else begin
                    sample_counter_next = sample_counter + 1'b1;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state <= st_idle;
            preamble_counter <= '0;
            sample_counter <= '0;
            dibit_index <= '0;
            byte_to_ship <= '0;
            shipped_data <= '0;
            shipped_data_valid <= 1'b0;
            data_ready <= 1'b0;
            speed_latched <= speed_100_megabit;
        end else begin
            state <= state_next;
            preamble_counter <= preamble_counter_next;
            sample_counter <= sample_counter_next;
            dibit_index <= dibit_index_next;
            byte_to_ship <= byte_to_ship_next;
            shipped_data <= shipped_data_next;
            shipped_data_valid <= shipped_data_valid_next;
            data_ready <= data_ready_next;
            speed_latched <= speed_latched_next;
        end
    end

    // No gap in tx_enable from preamble to last dibit
    assert property (@(posedge clock) disable iff (!reset_n)
        (state != st_idle) |-> shipped_data_valid)
        else $error("shipped_data_valid dropped inside a frame");

endmodule

`default_nettype wire

//--- hw/fcs_appender.sv
`timescale 1ns/1ps
`default_nettype none

module fcs_appender
    import rmii_tx_pkg::*;
(
    input  wire               clock,
    input  wire               reset_n,
    input  wire               frame_available,
    input  wire store_entry_t head_entry,
    output logic              pop,
    output tx_word_t          data,
    output logic              data_enable,
    input  wire               data_ready
);

    typedef enum logic [2:0] {
        st_wait,
        st_start,
        st_payload,
        st_fcs,
        st_end
    } state_t;

    state_t      state;
    logic [31:0] crc;
    logic [31:0] fcs_value;
    logic [1:0]  fcs_index;
    logic        last_popped;
    logic        advance;

    ////////////////////
    // CRC-32, LSB first

    function automatic logic [31:0] crc_update(input logic [31:0] crc_in, input logic [7:0] value);
        logic [31:0] c;
        c = crc_in ^ {24'd0, value};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ fcs_polynomial) : (c >> 1);
        end
        return c;
    endfunction

    function automatic logic [7:0] fcs_byte(input logic [31:0] fcs, input logic [1:0] index);
        return fcs[{index, 3'b000} +: 8];
    endfunction

    assign fcs_value = ~crc;

    // Fall of ready accepts the start word, later each ready pulse pulls a byte
    assign advance = (state == st_start && data_enable && !data_ready) ||
                     (state == st_payload && data_ready);

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state <= st_wait;
            pop <= 1'b0;
            data <= '0;
            data_enable <= 1'b0;
            crc <= fcs_residue_init;
            fcs_index <= '0;
            last_popped <= 1'b0;
        end else begin
            pop <= 1'b0;
            case (state)
                st_wait: begin
                    data_enable <= 1'b0;
                    if (frame_available && data_ready) begin
                        state <= st_start;
                    end
                end
                st_start, st_payload: begin
                    if (state == st_start && !data_enable) begin
                        // First byte carries the start marker
                        data <= '{marker: 1'b1, value: head_entry.value};
                        data_enable <= 1'b1;
                        pop <= 1'b1;
                        crc <= crc_update(fcs_residue_init, head_entry.value);
                        last_popped <= head_entry.last;
                    end else if (advance) begin
                        if (last_popped) begin
                            data <= '{marker: 1'b0, value: fcs_byte(fcs_value, 2'd0)};
                            fcs_index <= 2'd0;
                            state <= st_fcs;
                        end else begin
                            data <= '{marker: 1'b0, value: head_entry.value};
                            pop <= 1'b1;
                            crc <= crc_update(crc, head_entry.value);
                            last_popped <= head_entry.last;
                            state <= st_payload;
                        end
                    end
                end
                st_fcs: begin
                    if (data_ready) begin
                        if (fcs_index == 2'(fcs_bytes - 1)) begin
                            // enable stays low so idle shipper cannot restart on it
                            data <= '{marker: 1'b1, value: 8'h00};
                            data_enable <= 1'b0;
                            state <= st_end;
                        end else begin
                            fcs_index <= fcs_index + 2'd1;
                            data <= '{marker: 1'b0,
                                      value: fcs_byte(fcs_value, fcs_index + 2'd1)};
                        end
                    end
                end
                st_end: begin
                    // Shipper back in idle
                    if (data_ready) begin
                        state <= st_wait;
                    end
                end
                default: begin
                    state <= st_wait;
                end
            endcase
        end
    end

    // Shipper only holds ready high while idle, no byte pulls here
    assert property (@(posedge clock) disable iff (!reset_n)
        (state == st_wait) |-> !$fell(data_ready))
        else $error("data_ready pulse while appender waits for a frame");

endmodule

`default_nettype wire

//--- hw/tx_frame_store.sv
`timescale 1ns/1ps
`default_nettype none

module tx_frame_store #(
    parameter type payload_t = logic [7:0],
    parameter int STORE_DEPTH = 64
) (
    input  wire           clock,
    input  wire           reset_n,
    input  wire payload_t write_entry,
    input  wire           write_last,
    input  wire           write,
    output logic          full,
    output logic          frame_available,
    output payload_t      head_entry,
    input  wire           pop
);

    localparam int pointer_width = $clog2(STORE_DEPTH);
    localparam int count_width = $clog2(STORE_DEPTH + 1);

    payload_t                 entries [STORE_DEPTH];
    logic                     last_flags [STORE_DEPTH];
    logic [pointer_width-1:0] write_pointer;
    logic [pointer_width-1:0] read_pointer;
    logic [count_width-1:0]   entry_count;
    logic [count_width-1:0]   frame_count;
    logic                     write_accept;
    logic                     pop_accept;
    logic                     head_last;

    function automatic logic [pointer_width-1:0] wrap_next(input logic [pointer_width-1:0] p);
        if (p == pointer_width'(STORE_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign full = (entry_count == count_width'(STORE_DEPTH));
    assign write_accept = write && !full;
    assign pop_accept = pop && (entry_count != '0);
    assign head_entry = entries[read_pointer];
    assign head_last = last_flags[read_pointer];
    // Only whole frames are released downstream
    assign frame_available = (frame_count != '0);

    always_ff @(posedge clock) begin
        if (write_accept) begin
            entries[write_pointer] <= write_entry;
            last_flags[write_pointer] <= write_last;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            write_pointer <= '0;
            read_pointer <= '0;
            entry_count <= '0;
            frame_count <= '0;
        end else begin
            if (write_accept) begin
                write_pointer <= wrap_next(write_pointer);
            end
            if (pop_accept) begin
                read_pointer <= wrap_next(read_pointer);
            end
            case ({write_accept, pop_accept})
                2'b10: entry_count <= entry_count + 1'b1;
                2'b01: entry_count <= entry_count - 1'b1;
                default: entry_count <= entry_count;
            endcase
            case ({write_accept && write_last, pop_accept && head_last})
                2'b10: frame_count <= frame_count + 1'b1;
                2'b01: frame_count <= frame_count - 1'b1;
                default: frame_count <= frame_count;
            endcase
        end
    end

    // Host must respect store_full, the byte would be lost
    assert property (@(posedge clock) disable iff (!reset_n) write |-> !full)
        else $error("write to full frame store dropped");

    assert property (@(posedge clock) disable iff (!reset_n) pop |-> entry_count != '0)
        else $error("pop from empty frame store");

endmodule

`default_nettype wire

//--- hw/rmii_tx_pkg.sv
`default_nettype none

package rmii_tx_pkg;

    ////////////////////
    // Speed selection

    // Codes 2 and 3 fall back to 100 Mbit/s in the shipper
    typedef enum logic [1:0] {
        speed_10_megabit  = 2'd0,
        speed_100_megabit = 2'd1
    } speed_code_t;

    ////////////////////
    // Words between blocks

    // Marker on the first word is start of frame, on a later word end of frame
    typedef struct packed {
        logic       marker;
        logic [7:0] value;
    } tx_word_t;

    typedef struct packed {
        logic       last;
        logic [7:0] value;
    } store_entry_t;

    ////////////////////
    // Frame constants

    // 7 bytes of 0x55 plus the first three dibits of the SFD
    localparam int preamble_dibits = 31;
    localparam int dibits_per_byte = 4;
    localparam int hold_clocks_10_megabit = 10;
    localparam int fcs_bytes = 4;

    localparam logic [31:0] fcs_residue_init = 32'hFFFF_FFFF;
    localparam logic [31:0] fcs_polynomial = 32'hEDB8_8320;

endpackage

`default_nettype wire
